// ==== common/pgu_config.svh ====
// ------------------
// Sizes and register map of the page attribute unit
// Table depth must equal 2**PGU_INDEX_W
// Priority bank count is fixed at two by the read mux
// ------------------
`ifndef PGU_CONFIG_SVH
`define PGU_CONFIG_SVH

// --------------------
// Table geometry
`define PGU_PAGES       1024    // Pages per table
`define PGU_INDEX_W     10      // Physical page index width
`define PGU_FRAME_W     20      // Page map frame field
`define PGU_PRIO_W      12      // Priority entry width
`define PGU_PRIO_BANKS  2       // Priority banks

// --------------------
// Host bus and register map
`define PGU_DATA_W      32      // Wishbone data width
`define PGU_ADDR_W      3       // Register number width
`define PGU_ACC_RO_BIT  2       // Read-only flag position in ACCESS word
`define PGU_ACC_INV_BIT 1       // Invalid flag position in ACCESS word

`endif

// ==== common/pgu_pkg.sv ====
// ------------------
// Shared types of the page attribute unit
// Widths follow pgu_config.svh
// ------------------
`include "pgu_config.svh"

package pgu_pkg;

    // --------------------
    // Page table payloads
    typedef logic [`PGU_INDEX_W-1:0] page_index_t;    // Page number
    typedef logic [`PGU_FRAME_W-1:0] page_frame_t;    // Page map entry
    typedef logic [`PGU_PRIO_W-1:0]  page_prio_t;     // Priority entry

    typedef struct packed {
        logic ro;                                      // Page is read only
        logic inv;                                     // Page is invalid
    } page_access_t;

    // Register numbers; address 7 is unmapped and reads zero
    typedef enum logic [`PGU_ADDR_W-1:0] {
        PGU_REG_INDEX  = 3'd0,
        PGU_REG_MAP    = 3'd1,
        PGU_REG_ACCESS = 3'd2,
        PGU_REG_REPRIO = 3'd3,
        PGU_REG_PRIO0  = 3'd4,
        PGU_REG_PRIO1  = 3'd5,
        PGU_REG_FILL   = 3'd6
    } pgu_reg_e;

    // --------------------
    // Wishbone classic
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`PGU_ADDR_W-1:0] adr;                   // Register number
        logic [`PGU_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;                   // One cycle per access
        logic [`PGU_DATA_W-1:0] dat;                   // Valid with ack
    } wb_rsp_t;

    // Command broadcast from the bus front end to every table
    typedef struct packed {
        page_index_t                index;             // Current page
        logic                       we_map;
        logic                       we_access;
        logic                       we_reprio;
        logic [`PGU_PRIO_BANKS-1:0] we_prio;           // One per bank
        logic [`PGU_DATA_W-1:0]     wdata;             // Raw bus word
    } table_cmd_t;

endpackage

// ==== rtl/page_unit/pgu_table.sv ====
// ------------------
// Per-page table with one write port and a registered read
// Read returns old data when written in the same cycle
// Contents are not cleared by reset
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_table #(
    parameter type T = logic                // Payload per page
) (
    input  logic                 clk,
    input  pgu_pkg::page_index_t i_index,   // Page for read and write
    input  logic                 i_we,
    input  T                     i_wdata,
    output T                     o_rdata    // Entry at last cycle's index
);

    // --------------------
    // Storage
    T mem [`PGU_PAGES];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index] <= i_wdata;        // Write at current page
        end
    end

    // Registered read, one cycle behind the index
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_index];
    end

endmodule

// ==== rtl/page_unit/pgu_reprio_fill.sv ====
// ------------------
// Reprioritize bit per page with fill-with-ones sequencer
// A fill runs from the start index up to the last page
// Busy lasts PGU_PAGES minus start cycles; lower pages keep their bits
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_reprio_fill (
    input  logic                clk,
    input  logic                reset,
    input  pgu_pkg::table_cmd_t i_cmd,
    input  logic                i_fill_start,   // Start at i_cmd.index
    output logic                o_rdata,        // Bit at current page
    output logic                o_fill_busy     // Full-memory condition pending
);

    logic                 mem [`PGU_PAGES];     // Reprio bits
    pgu_pkg::page_index_t fcnt;                 // Next page to fill
    logic                 last_page;

    assign last_page = (fcnt == pgu_pkg::page_index_t'(`PGU_PAGES - 1));

    // --------------------
    // Sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            o_fill_busy <= 1'b0;
        end else if (o_fill_busy) begin
            if (last_page) begin
                o_fill_busy <= 1'b0;            // Page 1023 written this cycle
            end
        end else if (i_fill_start) begin
            o_fill_busy <= 1'b1;
        end
    end

    // Fill pointer
    always_ff @(posedge clk) begin
        if (o_fill_busy) begin
            fcnt <= fcnt + 1'b1;                // Wraps only after the stop
        end else if (i_fill_start) begin
            fcnt <= i_cmd.index;
        end
    end

    // --------------------
    // Bit memory
    always_ff @(posedge clk) begin
        if (o_fill_busy) begin
            mem[fcnt] <= 1'b1;                  // One page per cycle
        end else if (i_cmd.we_reprio) begin
            mem[i_cmd.index] <= i_cmd.wdata[0];
        end
    end

    // Registered read at the index register
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_cmd.index];
    end

endmodule

// ==== rtl/page_unit/pgu_read_mux.sv ====
// ------------------
// Wishbone read data return
// Selected value is zero-extended; ACCESS uses bits 2 and 1
// Unmapped address 7 reads as zero
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_read_mux (
    input  pgu_pkg::pgu_reg_e    i_rd_sel,                 // Registered, valid with ack
    input  pgu_pkg::page_index_t i_index,
    input  pgu_pkg::page_frame_t i_map,
    input  pgu_pkg::page_access_t i_access,
    input  logic                 i_reprio,
    input  pgu_pkg::page_prio_t  i_prio [`PGU_PRIO_BANKS],  // By bank number
    input  logic                 i_fill_busy,
    output logic [`PGU_DATA_W-1:0] o_dat
);

    always_comb begin
        o_dat = '0;                                         // Unused bits read zero
        case (i_rd_sel)
            pgu_pkg::PGU_REG_INDEX:  o_dat[`PGU_INDEX_W-1:0] = i_index;
            pgu_pkg::PGU_REG_MAP:    o_dat[`PGU_FRAME_W-1:0] = i_map;
            pgu_pkg::PGU_REG_ACCESS: begin
                o_dat[`PGU_ACC_RO_BIT]  = i_access.ro;      // Bit 0 stays zero
                o_dat[`PGU_ACC_INV_BIT] = i_access.inv;
            end
            pgu_pkg::PGU_REG_REPRIO: o_dat[0] = i_reprio;
            pgu_pkg::PGU_REG_PRIO0:  o_dat[`PGU_PRIO_W-1:0] = i_prio[0];
            pgu_pkg::PGU_REG_PRIO1:  o_dat[`PGU_PRIO_W-1:0] = i_prio[1];
            pgu_pkg::PGU_REG_FILL:   o_dat[0] = i_fill_busy;
            default:                 o_dat = '0;            // Address 7
        endcase
    end

endmodule

// ==== rtl/page_unit/pgu_bus_frontend.sv ====
// ------------------
// Wishbone classic slave front end
// Ack comes one cycle after a sampled access, never two in a row
// REPRIO accesses wait out a fill plus one idle cycle
// Index register changes only on an acknowledged write
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_bus_frontend (
    input  logic                clk,
    input  logic                reset,
    input  pgu_pkg::wb_req_t    i_wb,
    input  logic                i_fill_busy,
    output pgu_pkg::table_cmd_t o_cmd,
    output logic                o_fill_start,
    output logic                o_ack,
    output pgu_pkg::pgu_reg_e   o_rd_sel
);

    pgu_pkg::page_index_t index_q;      // Physical page index register
    logic                 busy_q;       // Busy one cycle ago
    logic                 is_reprio;
    logic                 stall;
    logic                 take;         // Access sampled this cycle
    logic                 wr_take;

    // --------------------
    // Access qualification
    assign is_reprio = (i_wb.adr == pgu_pkg::PGU_REG_REPRIO);
    assign stall     = is_reprio & (i_fill_busy | busy_q);  // Hold off until busy low a cycle
    assign take      = i_wb.cyc & i_wb.stb & ~o_ack & ~stall;
    assign wr_take   = take & i_wb.we;

    // --------------------
    // Table commands, issued in the sampling cycle
    always_comb begin
        o_cmd.index     = index_q;
        o_cmd.wdata     = i_wb.dat;                          // Tables keep their low bits
        o_cmd.we_map    = wr_take & (i_wb.adr == pgu_pkg::PGU_REG_MAP);
        o_cmd.we_access = wr_take & (i_wb.adr == pgu_pkg::PGU_REG_ACCESS);
        o_cmd.we_reprio = wr_take & is_reprio;
        for (int b = 0; b < `PGU_PRIO_BANKS; b++) begin
            // Banks sit on consecutive register numbers
            o_cmd.we_prio[b] = wr_take & (i_wb.adr == (pgu_pkg::PGU_REG_PRIO0 + b));
        end
    end

    // --------------------
    // Handshake, read select and fill start
    always_ff @(posedge clk) begin
        if (reset) begin
            o_ack        <= 1'b0;
            busy_q       <= 1'b0;
            o_fill_start <= 1'b0;
            o_rd_sel     <= pgu_pkg::PGU_REG_INDEX;
        end else begin
            o_ack  <= take;                                  // Single-cycle ack
            busy_q <= i_fill_busy;
            // Start pulse lands in the ack cycle, busy follows a cycle later
            o_fill_start <= wr_take & (i_wb.adr == pgu_pkg::PGU_REG_FILL)
                            & i_wb.dat[0] & ~i_fill_busy;
            if (take) begin
                // Address 7 passes through and decodes to zero in the read mux
                o_rd_sel <= pgu_pkg::pgu_reg_e'(i_wb.adr);
            end
        end
    end

    // Index register
    always_ff @(posedge clk) begin
        if (reset) begin
            index_q <= '0;
        end else if (wr_take && i_wb.adr == pgu_pkg::PGU_REG_INDEX) begin
            index_q <= i_wb.dat[`PGU_INDEX_W-1:0];           // Keep 10 bits
        end
    end

endmodule

// ==== rtl/page_unit/page_unit_top.sv ====
// ------------------
// Page attribute unit behind a Wishbone classic slave port
// Tables are addressed by the physical page index register
// o_fill_busy stands for the full-memory condition
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module page_unit_top (
    input  logic             clk,
    input  logic             reset,
    input  pgu_pkg::wb_req_t i_wb,
    output pgu_pkg::wb_rsp_t o_wb,
    output logic             o_fill_busy
);

    pgu_pkg::table_cmd_t   cmd;                         // Broadcast to every table
    logic                  fill_start;
    logic                  ack;
    pgu_pkg::pgu_reg_e     rd_sel;
    logic [`PGU_DATA_W-1:0] rd_dat;
    pgu_pkg::page_frame_t  map_rdata;
    pgu_pkg::page_access_t access_rdata;
    logic                  reprio_rdata;
    pgu_pkg::page_prio_t   prio_rdata [`PGU_PRIO_BANKS];

    assign o_wb = '{ack: ack, dat: rd_dat};

    // --------------------
    // Bus front end
    pgu_bus_frontend u_frontend (
        .clk          (clk),
        .reset        (reset),
        .i_wb         (i_wb),
        .i_fill_busy  (o_fill_busy),
        .o_cmd        (cmd),
        .o_fill_start (fill_start),
        .o_ack        (ack),
        .o_rd_sel     (rd_sel)
    );

    // Page map
    pgu_table #(.T(pgu_pkg::page_frame_t)) u_map (
        .clk     (clk),
        .i_index (cmd.index),
        .i_we    (cmd.we_map),
        .i_wdata (cmd.wdata[`PGU_FRAME_W-1:0]),
        .o_rdata (map_rdata)
    );

    // Access bits, ro and inv from data bits 2 and 1
    pgu_table #(.T(pgu_pkg::page_access_t)) u_access (
        .clk     (clk),
        .i_index (cmd.index),
        .i_we    (cmd.we_access),
        .i_wdata ('{ro: cmd.wdata[`PGU_ACC_RO_BIT], inv: cmd.wdata[`PGU_ACC_INV_BIT]}),
        .o_rdata (access_rdata)
    );

    // --------------------
    // Priority banks
    for (genvar b = 0; b < `PGU_PRIO_BANKS; b++) begin : g_prio
        pgu_table #(.T(pgu_pkg::page_prio_t)) u_prio (
            .clk     (clk),
            .i_index (cmd.index),
            .i_we    (cmd.we_prio[b]),
            .i_wdata (cmd.wdata[`PGU_PRIO_W-1:0]),
            .o_rdata (prio_rdata[b])
        );
    end

    // Reprio bits and fill sequencer
    pgu_reprio_fill u_reprio (
        .clk          (clk),
        .reset        (reset),
        .i_cmd        (cmd),
        .i_fill_start (fill_start),
        .o_rdata      (reprio_rdata),
        .o_fill_busy  (o_fill_busy)
    );

    // Read return
    pgu_read_mux u_read_mux (
        .i_rd_sel    (rd_sel),
        .i_index     (cmd.index),
        .i_map       (map_rdata),
        .i_access    (access_rdata),
        .i_reprio    (reprio_rdata),
        .i_prio      (prio_rdata),
        .i_fill_busy (o_fill_busy),
        .o_dat       (rd_dat)
    );

endmodule

// ==== verification/pgu_clock_gen.sv ====
// ------------------
// Testbench clock and reset source
// Reset is synchronous and released on a rising edge
// ------------------
`timescale 1ns/1ps

module pgu_clock_gen #(
    parameter int period_ns    = 8,         // Clock period
    parameter int reset_cycles = 8          // Cycles with reset high
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(period_ns / 2) o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (reset_cycles) @(posedge o_clk);
        o_reset <= 1'b0;                    // Released with the edge
    end

endmodule

// ==== verification/pgu_checker.sv ====
// ------------------
// Bound assertions on the page unit bus and fill status
// Sampled on the rising edge, idle while reset is high
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_checker (
    input logic             clk,
    input logic             reset,
    input pgu_pkg::wb_req_t i_wb,
    input pgu_pkg::wb_rsp_t i_rsp,
    input logic             i_fill_busy
);

    int fail_count = 0;                                     // Failed assertions so far

    // --------------------
    // Handshake
    ack_single: assert property (@(posedge clk) disable iff (reset)
        i_rsp.ack |=> !i_rsp.ack)                           // One cycle only
        else begin
            $error("ack stayed high for two cycles");
            fail_count++;
        end

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        i_rsp.ack |-> $past(i_wb.cyc && i_wb.stb))          // Sampled request first
        else begin
            $error("ack without a preceding cyc and stb cycle");
            fail_count++;
        end

    // --------------------
    // Fill
    reprio_not_during_fill: assert property (@(posedge clk) disable iff (reset)
        (i_rsp.ack && i_wb.adr == pgu_pkg::PGU_REG_REPRIO) |-> !i_fill_busy)
        else begin
            $error("REPRIO access acknowledged while fill busy");
            fail_count++;
        end

    fill_bounded: assert property (@(posedge clk) disable iff (reset)
        $rose(i_fill_busy) |-> ##[1:`PGU_PAGES] !i_fill_busy)   // Start at page 0 is longest
        else begin
            $error("fill busy longer than one pass over the table");
            fail_count++;
        end

endmodule

bind page_unit_top pgu_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .i_wb        (i_wb),
    .i_rsp       (o_wb),
    .i_fill_busy (o_fill_busy)
);

// ==== verification/pgu_tb.sv ====
// ------------------
// Table-driven testbench of the page attribute unit
// Expected reads come from a model of the register rules
// One Wishbone access at a time, outputs sampled on the falling edge
// ------------------
`timescale 1ns/1ps
`include "pgu_config.svh"

module pgu_tb;

    localparam int max_tests = 64;

    logic             clk;
    logic             reset;
    pgu_pkg::wb_req_t wb_req;
    pgu_pkg::wb_rsp_t wb_rsp;
    logic             fill_busy;

    // --------------------
    // Test table
    string                  t_name  [max_tests];
    logic [`PGU_ADDR_W-1:0] t_reg   [max_tests];
    logic                   t_write [max_tests];
    logic [`PGU_DATA_W-1:0] t_data  [max_tests];
    logic [`PGU_DATA_W-1:0] t_exp   [max_tests];
    logic                   t_stall [max_tests];    // Read must wait out a fill
    int                     n_tests = 0;

    // --------------------
    // Reference model
    logic [`PGU_INDEX_W-1:0] m_index;
    logic [`PGU_FRAME_W-1:0] m_map    [`PGU_PAGES];
    logic [1:0]              m_access [`PGU_PAGES];  // {ro, inv}
    logic                    m_reprio [`PGU_PAGES];
    logic [`PGU_PRIO_W-1:0]  m_prio   [`PGU_PRIO_BANKS][`PGU_PAGES];
    logic                    m_busy = 1'b0;

    logic [31:0] rng_state = 32'h874e;
    int          errors = 0;
    int          cycle_count = 0;
    int          timeout_cycles = 0;

    pgu_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    page_unit_top DUT (
        .clk         (clk),
        .reset       (reset),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .o_fill_busy (fill_busy)
    );

    // Xorshift32
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic void model_write(input logic [2:0] adr, input logic [31:0] dat);
        case (adr)
            pgu_pkg::PGU_REG_INDEX:  m_index = dat[`PGU_INDEX_W-1:0];
            pgu_pkg::PGU_REG_MAP:    m_map[m_index] = dat[`PGU_FRAME_W-1:0];
            pgu_pkg::PGU_REG_ACCESS: m_access[m_index] = {dat[2], dat[1]};
            pgu_pkg::PGU_REG_REPRIO: begin
                m_busy = 1'b0;                          // Write waits for fill end
                m_reprio[m_index] = dat[0];
            end
            pgu_pkg::PGU_REG_PRIO0:  m_prio[0][m_index] = dat[`PGU_PRIO_W-1:0];
            pgu_pkg::PGU_REG_PRIO1:  m_prio[1][m_index] = dat[`PGU_PRIO_W-1:0];
            pgu_pkg::PGU_REG_FILL: begin
                if (dat[0] && !m_busy) begin
                    for (int p = m_index; p < `PGU_PAGES; p++) begin
                        m_reprio[p] = 1'b1;             // Start page up to the last
                    end
                    m_busy = 1'b1;
                end
            end
            default: ;                                  // Address 7 ignores writes
        endcase
    endfunction

    function automatic logic [31:0] predict_read(input logic [2:0] adr);
        case (adr)
            pgu_pkg::PGU_REG_INDEX:  return 32'(m_index);
            pgu_pkg::PGU_REG_MAP:    return 32'(m_map[m_index]);
            pgu_pkg::PGU_REG_ACCESS: return {29'd0, m_access[m_index], 1'b0};
            pgu_pkg::PGU_REG_REPRIO: return 32'(m_reprio[m_index]);
            pgu_pkg::PGU_REG_PRIO0:  return 32'(m_prio[0][m_index]);
            pgu_pkg::PGU_REG_PRIO1:  return 32'(m_prio[1][m_index]);
            pgu_pkg::PGU_REG_FILL:   return 32'(m_busy);
            default:                 return 32'd0;
        endcase
    endfunction

    function automatic void add_write(input string name, input logic [2:0] adr,
                                      input logic [31:0] dat);
        t_name[n_tests]  = name;
        t_reg[n_tests]   = adr;
        t_write[n_tests] = 1'b1;
        t_data[n_tests]  = dat;
        t_exp[n_tests]   = '0;
        t_stall[n_tests] = 1'b0;
        n_tests++;
        model_write(adr, dat);
    endfunction

    function automatic void add_read(input string name, input logic [2:0] adr);
        t_name[n_tests]  = name;
        t_reg[n_tests]   = adr;
        t_write[n_tests] = 1'b0;
        t_data[n_tests]  = '0;
        t_stall[n_tests] = (adr == pgu_pkg::PGU_REG_REPRIO) && m_busy;
        if (adr == pgu_pkg::PGU_REG_REPRIO) begin
            m_busy = 1'b0;                              // Completes after the fill
        end
        t_exp[n_tests] = predict_read(adr);
        n_tests++;
    endfunction

    // --------------------
    // Stimulus table
    function automatic void build_table();
        logic [`PGU_INDEX_W-1:0] pages [3];
        pages = '{10'd5, 10'd517, 10'd1023};
        add_write("index_wr_rand", pgu_pkg::PGU_REG_INDEX, next_random());
        add_read("index_rd_masked", pgu_pkg::PGU_REG_INDEX);
        for (int k = 0; k < 3; k++) begin
            add_write($sformatf("map_index_%0d", k), pgu_pkg::PGU_REG_INDEX, 32'(pages[k]));
            add_write($sformatf("map_wr_%0d", k), pgu_pkg::PGU_REG_MAP, next_random());
        end
        for (int k = 0; k < 3; k++) begin
            add_write($sformatf("map_reindex_%0d", k), pgu_pkg::PGU_REG_INDEX, 32'(pages[k]));
            add_read($sformatf("map_rd_%0d", k), pgu_pkg::PGU_REG_MAP);
        end
        add_write("access_index", pgu_pkg::PGU_REG_INDEX, 32'd77);
        add_write("access_wr_rand", pgu_pkg::PGU_REG_ACCESS, next_random());
        add_read("access_rd_rand", pgu_pkg::PGU_REG_ACCESS);
        add_write("access_wr_both", pgu_pkg::PGU_REG_ACCESS, 32'h7);
        add_read("access_rd_both", pgu_pkg::PGU_REG_ACCESS);
        add_write("access_wr_bit0", pgu_pkg::PGU_REG_ACCESS, 32'h1);
        add_read("access_rd_bit0", pgu_pkg::PGU_REG_ACCESS);
        add_write("prio_index", pgu_pkg::PGU_REG_INDEX, 32'd300);
        add_write("prio0_wr", pgu_pkg::PGU_REG_PRIO0, next_random());
        add_write("prio1_wr", pgu_pkg::PGU_REG_PRIO1, next_random());
        add_read("prio0_rd", pgu_pkg::PGU_REG_PRIO0);
        add_read("prio1_rd", pgu_pkg::PGU_REG_PRIO1);
        add_write("fill_index_1000", pgu_pkg::PGU_REG_INDEX, 32'd1000);
        add_write("reprio_clr_1000", pgu_pkg::PGU_REG_REPRIO, 32'h0);
        add_write("fill_index_999", pgu_pkg::PGU_REG_INDEX, 32'd999);
        add_write("reprio_clr_999", pgu_pkg::PGU_REG_REPRIO, 32'h0);
        add_write("fill_start_index", pgu_pkg::PGU_REG_INDEX, 32'd1000);
        add_write("fill_start", pgu_pkg::PGU_REG_FILL, 32'h1);
        add_read("fill_busy_rd", pgu_pkg::PGU_REG_FILL);
        add_read("reprio_rd_stalled", pgu_pkg::PGU_REG_REPRIO);
        add_read("fill_done_rd", pgu_pkg::PGU_REG_FILL);
        add_write("below_index_999", pgu_pkg::PGU_REG_INDEX, 32'd999);
        add_read("reprio_rd_999", pgu_pkg::PGU_REG_REPRIO);
        add_write("addr7_wr", 3'd7, next_random());
        add_read("addr7_rd", 3'd7);
        add_read("index_after_addr7", pgu_pkg::PGU_REG_INDEX);
    endfunction

    // One Wishbone classic access, ack checked on falling edges
    task automatic run_access(input logic [2:0] adr, input logic we, input logic [31:0] dat,
                              output logic [31:0] rdat, output int waits);
        waits = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
            waits++;
        end while (wb_rsp.ack !== 1'b1);
        rdat = wb_rsp.dat;                              // Valid with ack
        @(posedge clk);
        wb_req <= '0;                                   // Release after ack
        @(negedge clk);
        if (wb_rsp.ack !== 1'b0) begin
            $display("error: ack stayed high after the access at address %0d", adr);
            errors++;
        end
    endtask

    // --------------------
    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles != 0 && cycle_count >= timeout_cycles) begin
            $display("timeout: ack never arrived within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdat;
        int          waits;
        int          fails;
        wb_req = '0;
        build_table();
        timeout_cycles = n_tests * 8 + 2048;
        while (reset !== 1'b0) @(negedge clk);
        if (wb_rsp.ack !== 1'b0 || fill_busy !== 1'b0) begin
            $display("error: ack or fill busy not low after reset");
            errors++;
        end
        for (int i = 0; i < n_tests; i++) begin
            fails = errors;
            run_access(t_reg[i], t_write[i], t_data[i], rdat, waits);
            if (!t_write[i] && rdat !== t_exp[i]) begin
                $display("mismatch %s: expected %h, actual %h", t_name[i], t_exp[i], rdat);
                errors++;
            end
            if (t_stall[i] && waits <= 2) begin
                $display("error %s: REPRIO read was not held off during the fill", t_name[i]);
                errors++;
            end
            $display("test %0d %s: %s", i, t_name[i], (errors == fails) ? "ok" : "failed");
        end
        if (DUT.u_checker.fail_count != 0) begin
            $display("error: %0d bus or fill assertions failed", DUT.u_checker.fail_count);
            errors += DUT.u_checker.fail_count;
        end
        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/pgu_pkg.sv
rtl/page_unit/pgu_table.sv
rtl/page_unit/pgu_reprio_fill.sv
rtl/page_unit/pgu_read_mux.sv
rtl/page_unit/pgu_bus_frontend.sv
rtl/page_unit/page_unit_top.sv
verification/pgu_clock_gen.sv
verification/pgu_checker.sv
verification/pgu_tb.sv

// ==== Bender.yml ====
package:
  name: page_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pgu_pkg.sv
      - rtl/page_unit/pgu_table.sv
      - rtl/page_unit/pgu_reprio_fill.sv
      - rtl/page_unit/pgu_read_mux.sv
      - rtl/page_unit/pgu_bus_frontend.sv
      - rtl/page_unit/page_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/pgu_clock_gen.sv
      - verification/pgu_checker.sv
      - verification/pgu_tb.sv
